// File: fb_dbuf_controller.sv
`timescale 1ns/1ps

module fb_dbuf_controller import gfx_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  logic       swap,
  input  fb_wr_req_t wr_req,
  input  logic       wr_valid,
  output logic       wr_ready,
  input  fb_rd_req_t rd_req,
  input  logic       rd_valid,
  output pixel_t     rd_data
);

  // two frame banks, index 0 and 1
  pixel_t mem [2][fb_depth];

  // bank currently shown on the display
  logic front;
  logic back;
  logic wr_fire;

  assign back = ~front;

  // hold writes off while the select flips
  assign wr_ready = ~swap;
  assign wr_fire = wr_valid & wr_ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      front <= 1'b0;
    end else if (swap) begin
      front <= ~front;
    end
  end

  // producer side, always the back bank
  always_ff @(posedge clk) begin
    if (wr_fire) begin
      mem[back][wr_req.addr] <= wr_req.data;
    end
  end

  // display side, one cycle read latency
  always_ff @(posedge clk) begin
    if (rd_valid) begin
      rd_data <= mem[front][rd_req.addr];
    end
  end

  // the bank a write lands in is still the back bank afterwards
  a_wr_back: assert property (
    @(posedge clk) disable iff (reset)
    wr_fire |=> (front == $past(front))
  ) else $error("write landed in the front bank");

  a_rd_range: assert property (
    @(posedge clk) disable iff (reset)
    rd_valid |-> (rd_req.addr < fb_addr_bits'(fb_depth))
  ) else $error("read address beyond the framebuffer");

endmodule

// File: fb_writer.sv
`timescale 1ns/1ps

module fb_writer import gfx_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  gfx_pixel_t pix,
  input  logic       pix_valid,
  output logic       inc,
  output fb_wr_req_t wr_req,
  output logic       wr_valid,
  input  logic       wr_ready
);

  logic [fb_addr_bits-1:0] lin_addr;

  // row-major position inside the bank
  assign lin_addr = fb_addr_bits'(pix.y * fb_width + pix.x);

  // room for a new pixel when empty or draining this cycle
  assign inc = ~wr_valid | wr_ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_valid <= 1'b0;
    end else if (inc) begin
      wr_valid <= pix_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (inc && pix_valid) begin
      wr_req.addr <= lin_addr;
      wr_req.data <= pix.color;
    end
  end

  // a stalled request must not change under the controller
  a_wr_hold: assert property (
    @(posedge clk) disable iff (reset)
    (wr_valid && !wr_ready) |=> (wr_valid && $stable(wr_req))
  ) else $error("write request changed while stalled");

endmodule

// File: files.f
gfx_pkg.sv
gfx_test_pattern.sv
fb_writer.sv
fb_dbuf_controller.sv
vga_fb_pixel_stream.sv
gfx_demo.sv
tb_gfx_demo.sv

// File: gfx_demo.sv
`timescale 1ns/1ps

module gfx_demo import gfx_pkg::*; (
  input  logic clk,
  input  logic reset,
  output logic hsync,
  output logic vsync,
  output logic de,
  output rgb_t color
);

  gfx_pixel_t gfx_pix;
  logic       gfx_valid;
  logic       gfx_last;
  logic       gfx_inc;
  fb_wr_req_t wr_req;
  logic       wr_valid;
  logic       wr_ready;
  fb_rd_req_t rd_req;
  logic       rd_valid;
  pixel_t     rd_data;
  logic       swap;
  logic       vsync_start;
  logic       gfx_ready;
  logic       gfx_ready_q;
  logic       gfx_ready_rise;
  logic       frame_done;
  logic       last_pending;
  logic       last_taken;
  logic       last_written;

  gfx_test_pattern u_pattern (
    .clk   (clk),
    .reset (reset),
    .inc   (gfx_inc),
    .swap  (swap),
    .pix   (gfx_pix),
    .valid (gfx_valid),
    .last  (gfx_last)
  );

  fb_writer u_writer (
    .clk       (clk),
    .reset     (reset),
    .pix       (gfx_pix),
    .pix_valid (gfx_valid),
    .inc       (gfx_inc),
    .wr_req    (wr_req),
    .wr_valid  (wr_valid),
    .wr_ready  (wr_ready)
  );

  fb_dbuf_controller u_dbuf (
    .clk      (clk),
    .reset    (reset),
    .swap     (swap),
    .wr_req   (wr_req),
    .wr_valid (wr_valid),
    .wr_ready (wr_ready),
    .rd_req   (rd_req),
    .rd_valid (rd_valid),
    .rd_data  (rd_data)
  );

  // display runs once the first swap has taken effect
  vga_fb_pixel_stream u_stream (
    .clk         (clk),
    .reset       (reset),
    .enable      (gfx_ready_q),
    .rd_req      (rd_req),
    .rd_valid    (rd_valid),
    .rd_data     (rd_data),
    .hsync       (hsync),
    .vsync       (vsync),
    .vsync_start (vsync_start),
    .de          (de),
    .color       (color)
  );

  // the last pixel sits in the writer for a while after the engine hands it over
  assign last_taken = gfx_valid & gfx_inc & gfx_last;
  assign last_written = last_pending & wr_valid & wr_ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      last_pending <= 1'b0;
      gfx_ready <= 1'b0;
      gfx_ready_q <= 1'b0;
      frame_done <= 1'b0;
    end else begin
      if (last_taken) begin
        last_pending <= 1'b1;
      end else if (last_written) begin
        last_pending <= 1'b0;
      end
      if (last_written) begin
        gfx_ready <= 1'b1;
      end
      gfx_ready_q <= gfx_ready;
      // a swap hands the finished frame to the display
      if (swap) begin
        frame_done <= 1'b0;
      end else if (last_written) begin
        frame_done <= 1'b1;
      end
    end
  end

  assign gfx_ready_rise = gfx_ready & ~gfx_ready_q;

  // first swap on startup, then only at vsync with a complete back frame
  assign swap = gfx_ready_rise | (vsync_start & frame_done);

  a_swap_pulse: assert property (
    @(posedge clk) disable iff (reset)
    swap |=> !swap
  ) else $error("swap held high for two cycles");

endmodule

// File: gfx_pkg.sv
package gfx_pkg;

  // active raster
  localparam int fb_width = 16;
  localparam int fb_height = 12;

  // full raster including blanking
  localparam int h_total = 20;
  localparam int v_total = 14;

  // sync placement, active high
  localparam int h_sync_start = 17;
  localparam int h_sync_len = 2;
  localparam int v_sync_start = 12;
  localparam int v_sync_len = 1;

  // one bank holds a whole frame
  localparam int fb_depth = fb_width * fb_height;
  localparam int fb_addr_bits = 8;

  localparam int pixel_bits = 12;
  localparam int color_bits = 4;

  // position widths inside the active area and raster counter width
  localparam int fb_x_bits = 4;
  localparam int fb_y_bits = 4;
  localparam int cnt_bits = 5;

  typedef struct packed {
    logic [color_bits-1:0] red;
    logic [color_bits-1:0] grn;
    logic [color_bits-1:0] blu;
  } rgb_t;

  // memory stores raw, display decodes rgb
  typedef union packed {
    logic [pixel_bits-1:0] raw;
    rgb_t                  rgb;
  } pixel_t;

  typedef struct packed {
    logic [fb_addr_bits-1:0] addr;
    pixel_t                  data;
  } fb_wr_req_t;

  typedef struct packed {
    logic [fb_addr_bits-1:0] addr;
  } fb_rd_req_t;

  typedef struct packed {
    logic [fb_x_bits-1:0] x;
    logic [fb_y_bits-1:0] y;
    pixel_t               color;
  } gfx_pixel_t;

endpackage

// File: gfx_test_pattern.sv
`timescale 1ns/1ps

module gfx_test_pattern import gfx_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  logic       inc,
  input  logic       swap,
  output gfx_pixel_t pix,
  output logic       valid,
  output logic       last
);

  logic [fb_x_bits-1:0]  x;
  logic [fb_y_bits-1:0]  y;
  logic [pixel_bits-1:0] frame;
  logic                  done;
  logic                  x_end;
  logic                  at_end;

  assign x_end = (x == fb_x_bits'(fb_width - 1));
  assign at_end = x_end && (y == fb_y_bits'(fb_height - 1));

  // stays quiet after the final pixel until the buffers are swapped
  assign valid = ~done;
  assign last = valid & at_end;

  always_comb begin
    pix.x = x;
    pix.y = y;
    // colour wraps naturally at 12 bits
    pix.color.raw = pixel_bits'(y * fb_width) + pixel_bits'(x) + frame;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      x <= '0;
      y <= '0;
      frame <= '0;
      done <= 1'b0;
    end else if (swap) begin
      x <= '0;
      y <= '0;
      frame <= frame + 1'b1;
      done <= 1'b0;
    end else if (valid && inc) begin
      if (at_end) begin
        done <= 1'b1;
      end else if (x_end) begin
        x <= '0;
        y <= y + 1'b1;
      end else begin
        x <= x + 1'b1;
      end
    end
  end

endmodule

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_gfx_demo \
  -f files.f -o sim_gfx_demo > build.log 2>&1
if [ $? -ne 0 ]; then
  echo "build failed, see build.log"
  exit 1
fi

./obj_dir/sim_gfx_demo > sim.log 2>&1
if [ $? -ne 0 ]; then
  echo "simulation exited with an error, see sim.log"
  exit 1
fi

if grep -q -x "all tests passed" sim.log; then
  echo "PASS"
  exit 0
fi
echo "FAIL, see sim.log"
exit 1

// File: tb_gfx_demo.sv
`timescale 1ns/1ps

module tb_gfx_demo import gfx_pkg::*; ();

  logic clk;
  logic reset;
  logic hsync;
  logic vsync;
  logic de;
  rgb_t color;

  int errs [1:5];
  int tests_passed;
  int tests_failed;

  // raster observers, all sampled on the rising edge
  logic de_q, hs_q, vs_q;
  logic seen_de, hs_seen, vs_seen;
  int col, row, frames_done;
  int hs_len, hs_per, vs_len, vs_per;
  logic [pixel_bits-1:0] frame_off;
  logic [pixel_bits-1:0] pos;
  logic [pixel_bits-1:0] off_now;
  logic [pixel_bits-1:0] exp_raw;
  pixel_t shown;
  logic first_px;

  gfx_demo i_dut (
    .clk   (clk),
    .reset (reset),
    .hsync (hsync),
    .vsync (vsync),
    .de    (de),
    .color (color)
  );

  always #2 clk = ~clk;

  assign shown = pixel_t'(color);
  assign pos = pixel_bits'(row * fb_width + col);
  // offset of this pixel from its linear position, i.e. the frame number drawn
  assign off_now = shown.raw - pos;
  assign exp_raw = pos + frame_off;
  assign first_px = de && (col == 0) && (row == 0);

  always @(posedge clk) begin
    if (reset) begin
      {de_q, hs_q, vs_q, seen_de, hs_seen, vs_seen} <= '0;
      {col, row, frames_done, hs_len, hs_per, vs_len, vs_per} <= '0;
      frame_off <= '0;
    end else begin
      de_q <= de;
      hs_q <= hsync;
      vs_q <= vsync;
      if (de) seen_de <= 1'b1;
      col <= de ? col + 1 : 0;
      // a line ends on the falling de, a frame on vsync
      if (vsync) row <= 0;
      else if (de_q && !de) row <= row + 1;
      hs_len <= hsync ? hs_len + 1 : 0;
      vs_len <= vsync ? vs_len + 1 : 0;
      if (hsync && !hs_q) begin
        hs_per <= 1;
        hs_seen <= 1'b1;
      end else begin
        hs_per <= hs_per + 1;
      end
      if (vsync && !vs_q) begin
        vs_per <= 1;
        vs_seen <= 1'b1;
        frames_done <= frames_done + 1;
      end else begin
        vs_per <= vs_per + 1;
      end
      if (first_px) frame_off <= off_now;
    end
  end

  task automatic note_mismatch(input int test, input string sig, input int exp, input int act);
    errs[test] = errs[test] + 1;
    $display("FAILED at %0t: %s expected %0d, got %0d", $time, sig, exp, act);
  endtask

  task automatic note_problem(input int test, input string what);
    errs[test] = errs[test] + 1;
    $display("error at %0t: %s", $time, what);
  endtask

  task automatic finish_test(input int test, input string name);
    if (errs[test] == 0) begin
      tests_passed++;
      $display("test %0d %s: pass", test, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: fail with %0d errors", test, name, errs[test]);
    end
  endtask

  task automatic wait_first_de(input int limit);
    int cycles;
    cycles = 0;
    while (!seen_de && cycles < limit) begin
      @(posedge clk);
      cycles++;
    end
    if (!seen_de) note_problem(1, "timed out waiting for the first de");
  endtask

  task automatic wait_frames(input int count, input int limit);
    int cycles;
    cycles = 0;
    while (frames_done < count && cycles < limit) begin
      @(posedge clk);
      cycles++;
    end
    if (frames_done < count) note_problem(5, "timed out waiting for displayed frames");
  endtask

  a_quiet: assert property (@(posedge clk) disable iff (reset)
    !seen_de |-> (!hsync && !vsync))
    else note_problem(1, "sync active before the first de");

  a_line_width: assert property (@(posedge clk) disable iff (reset)
    (de_q && !de) |-> (col == fb_width))
    else note_mismatch(2, "de cycles per line", fb_width, $sampled(col));
  a_frame_lines: assert property (@(posedge clk) disable iff (reset)
    (vsync && !vs_q) |-> (row == fb_height))
    else note_mismatch(2, "de lines per frame", fb_height, $sampled(row));
  a_hsync_len: assert property (@(posedge clk) disable iff (reset)
    (hs_q && !hsync) |-> (hs_len == h_sync_len))
    else note_mismatch(2, "hsync length", h_sync_len, $sampled(hs_len));
  a_hsync_period: assert property (@(posedge clk) disable iff (reset)
    (hsync && !hs_q && hs_seen) |-> (hs_per == h_total))
    else note_mismatch(2, "hsync period", h_total, $sampled(hs_per));
  a_vsync_len: assert property (@(posedge clk) disable iff (reset)
    (vs_q && !vsync) |-> (vs_len == v_sync_len * h_total))
    else note_mismatch(2, "vsync length", v_sync_len * h_total, $sampled(vs_len));
  a_vsync_period: assert property (@(posedge clk) disable iff (reset)
    (vsync && !vs_q && vs_seen) |-> (vs_per == v_total * h_total))
    else note_mismatch(2, "vsync period", v_total * h_total, $sampled(vs_per));

  // frame 0 carries no offset at all
  a_frame_zero: assert property (@(posedge clk) disable iff (reset)
    (de && frames_done == 0) |-> (shown.raw == pos))
    else note_mismatch(3, "color.raw", $sampled(pos), $sampled(shown.raw));

  a_whole_frame: assert property (@(posedge clk) disable iff (reset)
    (de && !first_px) |-> (off_now == frame_off))
    else note_mismatch(4, "color.raw", $sampled(exp_raw), $sampled(shown.raw));

  a_step: assert property (@(posedge clk) disable iff (reset)
    (first_px && frames_done > 0) |-> (pixel_bits'(off_now - frame_off) <= 1))
    else note_mismatch(5, "frame offset", $sampled(frame_off) + 1, $sampled(off_now));
  a_progress: assert property (@(posedge clk) disable iff (reset)
    (first_px && frames_done == 5) |-> (off_now >= 2))
    else note_problem(5, "displayed frame advanced fewer than twice over six frames");

  initial begin
    clk = 1'b0;
    reset = 1'b1;
    tests_passed = 0;
    tests_failed = 0;
    foreach (errs[i]) errs[i] = 0;
    repeat (5) @(posedge clk);
    reset <= 1'b0;
    wait_first_de(600);
    finish_test(1, "quiet until display enabled");
    // six full frames, so the step and progress checks are reached
    wait_frames(6, 2400);
    @(posedge clk);
    finish_test(2, "raster shape");
    finish_test(3, "first frame content");
    finish_test(4, "frames are whole");
    finish_test(5, "frames advance at vsync");
    $display("tests: %0d passed, %0d failed", tests_passed, tests_failed);
    if (tests_failed == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// File: vga_fb_pixel_stream.sv
`timescale 1ns/1ps

module vga_fb_pixel_stream import gfx_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  logic       enable,
  output fb_rd_req_t rd_req,
  output logic       rd_valid,
  input  pixel_t     rd_data,
  output logic       hsync,
  output logic       vsync,
  output logic       vsync_start,
  output logic       de,
  output rgb_t       color
);

  logic [cnt_bits-1:0] h_cnt;
  logic [cnt_bits-1:0] v_cnt;
  logic                h_end;
  logic                v_end;
  logic                active;
  logic                h_in_sync;
  logic                v_in_sync;

  assign h_end = (h_cnt == cnt_bits'(h_total - 1));
  assign v_end = (v_cnt == cnt_bits'(v_total - 1));

  // counters sit at the origin until the display is enabled
  always_ff @(posedge clk) begin
    if (reset) begin
      h_cnt <= '0;
      v_cnt <= '0;
    end else if (enable) begin
      if (h_end) begin
        h_cnt <= '0;
        if (v_end) begin
          v_cnt <= '0;
        end else begin
          v_cnt <= v_cnt + 1'b1;
        end
      end else begin
        h_cnt <= h_cnt + 1'b1;
      end
    end
  end

  assign active = enable &&
                  (h_cnt < cnt_bits'(fb_width)) &&
                  (v_cnt < cnt_bits'(fb_height));

  assign h_in_sync = (h_cnt >= cnt_bits'(h_sync_start)) &&
                     (h_cnt < cnt_bits'(h_sync_start + h_sync_len));
  assign v_in_sync = (v_cnt >= cnt_bits'(v_sync_start)) &&
                     (v_cnt < cnt_bits'(v_sync_start + v_sync_len));

  // one read per visible position
  assign rd_valid = active;
  assign rd_req.addr = fb_addr_bits'(v_cnt * fb_width + h_cnt);

  // first cycle of vertical sync, used as the swap point
  assign vsync_start = enable &&
                       (v_cnt == cnt_bits'(v_sync_start)) &&
                       (h_cnt == '0);

  // delayed one cycle to meet the read data
  always_ff @(posedge clk) begin
    if (reset) begin
      hsync <= 1'b0;
      vsync <= 1'b0;
      de <= 1'b0;
    end else begin
      hsync <= enable && h_in_sync;
      vsync <= enable && v_in_sync;
      de <= active;
    end
  end

  // blank outside the active area
  assign color = de ? rd_data.rgb : '0;

endmodule
